// File: absorb_pkg.sv
package absorb_pkg;

    // Datapath geometry
    localparam int WORD_W      = 32;
    localparam int BLOCK_WORDS = 4;
    localparam int DIGEST_W    = WORD_W * BLOCK_WORDS;

    // Index into a block, and a fill counter that can also hold BLOCK_WORDS
    localparam int WORD_IDX_W = $clog2(BLOCK_WORDS);
    localparam int FILL_W     = $clog2(BLOCK_WORDS + 1);

    // Header layout: block count in the low byte, output mode just above it
    localparam int COUNT_W       = 8;
    localparam int HDR_COUNT_LSB = 0;
    localparam int HDR_MODE_BIT  = 8;

    typedef logic [WORD_W-1:0] word_t;

    // One block as it is buffered and absorbed, word 0 first
    typedef word_t block_t [BLOCK_WORDS];

    // Packed digest with state word 0 in the low bits
    typedef logic [DIGEST_W-1:0] digest_t;

    typedef logic [COUNT_W-1:0] count_t;

    // Loader control states
    typedef enum logic [1:0] {
        restart,
        wait_header,
        wait_load,
        load
    } load_state_t;

endpackage

// File: block_if.sv
interface block_if import absorb_pkg::*; ();

    // Block words held in the input buffer
    block_t blk;

    // Set by the handoff strobe, cleared when the absorber takes the block
    logic pending;

    // Tags captured with the block
    logic last;
    logic mode;

    // One-cycle strobe from the absorber
    logic take;

    modport buf_side (output blk, pending, last, mode, input take);

    modport abs_side (input blk, pending, last, mode, output take);

endinterface

// File: load_fsm.sv
module load_fsm import absorb_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic buffer_empty,
    input  logic buffer_full,
    input  logic last_input_block,

    output logic in_ready,
    output logic load_enable,
    output logic control_regs_enable,
    output logic copy_control_regs_en,
    output logic input_buffer_ready_wr
);

    load_state_t current_state;
    load_state_t next_state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            current_state <= restart;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state            = current_state;
        in_ready              = 1'b0;
        load_enable           = 1'b0;
        control_regs_enable   = 1'b0;
        copy_control_regs_en  = 1'b0;
        input_buffer_ready_wr = 1'b0;

        unique case (current_state)
            // Single pass state after reset
            restart: begin
                next_state = wait_header;
            end

            // The first valid word of a message is the header. It is consumed
            // here so that it never reaches the buffer
            wait_header: begin
                if (in_valid) begin
                    in_ready            = 1'b1;
                    control_regs_enable = 1'b1;
                    next_state          = wait_load;
                end
            end

            // Hold off the source until the absorber has taken the previous block
            wait_load: begin
                if (buffer_empty) begin
                    // The previous last block is already tagged and gone, so the
                    // second-stage mode can follow the current message
                    copy_control_regs_en = 1'b1;
                    next_state           = load;
                end
            end

            // One word per handshake until the block is complete
            load: begin
                if (!buffer_full) begin
                    if (in_valid) begin
                        in_ready    = 1'b1;
                        load_enable = 1'b1;
                    end
                end else begin
                    input_buffer_ready_wr = 1'b1;
                    next_state = last_input_block ? wait_header : wait_load;
                end
            end

            default: begin
                next_state = restart;
            end
        endcase
    end

endmodule

// File: control_regs.sv
module control_regs import absorb_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t in_data,
    input  logic  control_regs_enable,
    input  logic  input_buffer_ready_wr,
    input  logic  copy_control_regs_en,

    output logic  last_input_block,
    output logic  stage2_mode
);

    // First stage: blocks still to be handed off, and the header mode
    count_t blocks_left;
    logic   stage1_mode;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blocks_left <= '0;
            stage1_mode <= 1'b0;
        end else if (control_regs_enable) begin
            blocks_left <= in_data[HDR_COUNT_LSB +: COUNT_W];
            stage1_mode <= in_data[HDR_MODE_BIT];
        end else if (input_buffer_ready_wr) begin
            blocks_left <= blocks_left - count_t'(1);
        end
    end

    // Second stage copy, read by the buffer when it tags a block
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage2_mode <= 1'b0;
        end else if (copy_control_regs_en) begin
            stage2_mode <= stage1_mode;
        end
    end

    assign last_input_block = (blocks_left == count_t'(1));

endmodule

// File: sipo_buffer.sv
module sipo_buffer import absorb_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t in_data,
    input  logic  load_enable,
    input  logic  input_buffer_ready_wr,
    input  logic  last_input_block,
    input  logic  stage2_mode,

    output logic  buffer_empty,
    output logic  buffer_full,

    block_if.buf_side bus
);

    logic [FILL_W-1:0] fill_cnt;
    block_t            words;

    // Word storage, addressed by the fill counter
    always_ff @(posedge clk) begin
        if (load_enable) begin
            words[fill_cnt[WORD_IDX_W-1:0]] <= in_data;
        end
    end

    // The counter stays at BLOCK_WORDS until the absorber takes the block,
    // which keeps the buffer full and the loader stalled
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_cnt    <= '0;
            bus.pending <= 1'b0;
            bus.last    <= 1'b0;
            bus.mode    <= 1'b0;
        end else begin
            if (bus.take) begin
                fill_cnt    <= '0;
                bus.pending <= 1'b0;
            end else if (load_enable) begin
                fill_cnt <= fill_cnt + FILL_W'(1);
            end

            if (input_buffer_ready_wr) begin
                bus.pending <= 1'b1;
                bus.last    <= last_input_block;
                bus.mode    <= stage2_mode;
            end
        end
    end

    assign bus.blk = words;

    assign buffer_empty = (fill_cnt == FILL_W'(0));
    assign buffer_full  = (fill_cnt == FILL_W'(BLOCK_WORDS));

endmodule

// File: block_absorber.sv
module block_absorber import absorb_pkg::*; (
    input  logic    clk,
    input  logic    rst,

    block_if.abs_side bus,

    output digest_t digest,
    output logic    digest_valid
);

    // Absorbing a block, and the single cycle that presents the digest
    logic busy;
    logic emit;

    logic [WORD_IDX_W-1:0] idx;
    logic                  last_q;
    logic                  mode_q;

    block_t  blk_q;
    block_t  state;
    word_t   mixed;
    digest_t packed_state;

    assign bus.take = bus.pending && !busy && !emit;

    // Local copy so the buffer can refill while this block is absorbed
    always_ff @(posedge clk) begin
        if (bus.take) begin
            blk_q <= bus.blk;
        end
    end

    assign mixed = state[idx] ^ blk_q[idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            emit   <= 1'b0;
            idx    <= '0;
            last_q <= 1'b0;
            mode_q <= 1'b0;
            state  <= '{default: '0};
        end else if (bus.take) begin
            busy   <= 1'b1;
            idx    <= '0;
            last_q <= bus.last;
            mode_q <= bus.mode;
        end else if (busy) begin
            // XOR in one word and rotate left by one bit
            state[idx] <= {mixed[WORD_W-2:0], mixed[WORD_W-1]};
            idx        <= idx + WORD_IDX_W'(1);
            if (idx == WORD_IDX_W'(BLOCK_WORDS - 1)) begin
                busy <= 1'b0;
                emit <= last_q;
            end
        end else if (emit) begin
            // Digest is out this cycle, start the next message from zero
            emit  <= 1'b0;
            state <= '{default: '0};
        end
    end

    always_comb begin
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            packed_state[i*WORD_W +: WORD_W] = state[i];
        end
    end

    // Mode 1 inverts every digest bit
    assign digest       = packed_state ^ {DIGEST_W{mode_q}};
    assign digest_valid = emit;

endmodule

// File: absorb_top.sv
module absorb_top import absorb_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  word_t   in_data,
    input  logic    in_valid,
    output logic    in_ready,
    output digest_t digest,
    output logic    digest_valid
);

    logic load_enable;
    logic control_regs_enable;
    logic copy_control_regs_en;
    logic input_buffer_ready_wr;
    logic buffer_empty;
    logic buffer_full;
    logic last_input_block;
    logic stage2_mode;

    block_if blk_bus ();

    load_fsm u_load_fsm (
        .clk                   (clk),
        .rst                   (rst),
        .in_valid              (in_valid),
        .buffer_empty          (buffer_empty),
        .buffer_full           (buffer_full),
        .last_input_block      (last_input_block),
        .in_ready              (in_ready),
        .load_enable           (load_enable),
        .control_regs_enable   (control_regs_enable),
        .copy_control_regs_en  (copy_control_regs_en),
        .input_buffer_ready_wr (input_buffer_ready_wr)
    );

    control_regs u_control_regs (
        .clk                   (clk),
        .rst                   (rst),
        .in_data               (in_data),
        .control_regs_enable   (control_regs_enable),
        .input_buffer_ready_wr (input_buffer_ready_wr),
        .copy_control_regs_en  (copy_control_regs_en),
        .last_input_block      (last_input_block),
        .stage2_mode           (stage2_mode)
    );

    sipo_buffer u_sipo_buffer (
        .clk                   (clk),
        .rst                   (rst),
        .in_data               (in_data),
        .load_enable           (load_enable),
        .input_buffer_ready_wr (input_buffer_ready_wr),
        .last_input_block      (last_input_block),
        .stage2_mode           (stage2_mode),
        .buffer_empty          (buffer_empty),
        .buffer_full           (buffer_full),
        .bus                   (blk_bus.buf_side)
    );

    block_absorber u_block_absorber (
        .clk          (clk),
        .rst          (rst),
        .bus          (blk_bus.abs_side),
        .digest       (digest),
        .digest_valid (digest_valid)
    );

endmodule

// File: absorb_assert.sv
module absorb_assert (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic in_ready,
    input logic digest_valid
);

    // The loader only ever answers a valid word
    ready_needs_valid: assert property (@(posedge clk) disable iff (rst)
        in_ready |-> in_valid)
        else $error("in_ready high while in_valid is low");

    // Digest is a single-cycle strobe
    digest_strobe: assert property (@(posedge clk) disable iff (rst)
        digest_valid |=> !digest_valid)
        else $error("digest_valid held for two cycles");

    reset_quiet: assert property (@(posedge clk) rst |-> !in_ready)
        else $error("in_ready high during reset");

endmodule

bind absorb_top absorb_assert u_absorb_assert (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .digest_valid (digest_valid)
);

// File: absorb_tb.sv
module absorb_tb import absorb_pkg::*; ();

    localparam int CLK_PERIOD = 40;

    logic    clk;
    logic    rst;
    word_t   in_data;
    logic    in_valid;
    logic    in_ready;
    digest_t digest;
    logic    digest_valid;

    // Every message as it goes on the wire, header first
    word_t   stim_q[$];
    digest_t exp_q[$];
    digest_t expected;

    int total_words;
    int msg_count;
    int digest_count;
    int error_count;
    int tests_passed;
    int tests_failed;

    absorb_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Budget of 8 cycles per word on top of a fixed margin
    initial begin
        @(negedge rst);
        repeat (total_words * 8 + 200) @(posedge clk);
        $display("Timeout: digests still missing after %0d cycles", total_words * 8 + 200);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic void add_message(input int blocks, input logic mode);
        word_t hdr;
        hdr = '0;
        hdr[HDR_COUNT_LSB +: COUNT_W] = count_t'(blocks);
        hdr[HDR_MODE_BIT] = mode;
        stim_q.push_back(hdr);
        for (int i = 0; i < blocks * BLOCK_WORDS; i++) begin
            stim_q.push_back($urandom());
        end
    endfunction

    // Each data word is XORed into state word (index mod 4), then rotated left by one
    function automatic void reference_digest(input word_t words[$], input logic mode);
        word_t   st[BLOCK_WORDS];
        word_t   mix;
        digest_t result;
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            st[i] = '0;
        end
        for (int w = 0; w < words.size(); w++) begin
            mix = st[w % BLOCK_WORDS] ^ words[w];
            st[w % BLOCK_WORDS] = (mix << 1) | (mix >> (WORD_W - 1));
        end
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            result[i*WORD_W +: WORD_W] = st[i];
        end
        exp_q.push_back(mode ? ~result : result);
    endfunction

    // Inputs change on the falling edge, in_ready is read a quarter period later
    task automatic send_word(input word_t w, input bit gaps);
        int idle;
        bit accepted;
        idle = gaps ? int'($urandom_range(3, 0)) : 0;
        repeat (idle) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
        @(negedge clk);
        in_data  = w;
        in_valid = 1'b1;
        do begin
            #(CLK_PERIOD / 4);
            accepted = in_ready;
            @(posedge clk);
        end while (!accepted);
    endtask

    task automatic send_message(input bit gaps);
        word_t hdr;
        word_t data_q[$];
        int    n_data;
        hdr    = stim_q.pop_front();
        n_data = BLOCK_WORDS * int'(hdr[HDR_COUNT_LSB +: COUNT_W]);
        for (int i = 0; i < n_data; i++) begin
            data_q.push_back(stim_q[i]);
        end
        reference_digest(data_q, hdr[HDR_MODE_BIT]);
        msg_count++;
        send_word(hdr, gaps);
        repeat (n_data) send_word(stim_q.pop_front(), gaps);
    endtask

    function automatic void report_test(input int id, input string name, input int errs_before);
        if (error_count == errs_before) begin
            tests_passed++;
            $display("test %0d (%s) ok", id, name);
        end else begin
            tests_failed++;
            $display("test %0d (%s) had %0d errors", id, name, error_count - errs_before);
        end
    endfunction

    task automatic run_test(input int id, input string name, input int n_msgs, input bit gaps);
        int errs_before;
        errs_before = error_count;
        repeat (n_msgs) send_message(gaps);
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        report_test(id, name, errs_before);
    endtask

    // Digest outputs are registered, so they are read in the middle of the cycle
    always @(negedge clk) begin
        if (digest_valid) begin
            digest_count++;
            assert (exp_q.size() > 0) else begin
                $display("Unexpected digest_valid with no message outstanding");
                error_count++;
            end
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                assert (digest === expected) else begin
                    $display("error digest expected 0x%h actual 0x%h", expected, digest);
                    error_count++;
                end
            end
        end
    end

    initial begin
        int   errs_before;
        int   quiet_start;
        int   blocks;
        logic mode;
        void'($urandom(9372));
        rst = 1'b1;
        add_message(1, 1'b0);
        add_message(5, 1'b1);
        repeat (16) begin
            blocks = $urandom_range(6, 1);
            mode   = 1'($urandom_range(1, 0));
            add_message(blocks, mode);
        end
        total_words = stim_q.size();

        // The first header is already offered during reset and held until the
        // loader has left restart and accepts it
        in_data  = stim_q[0];
        in_valid = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_test(1, "one block, mode 0", 1, 1'b0);
        run_test(2, "five blocks, mode 1", 1, 1'b0);
        run_test(3, "ten back-to-back random messages", 10, 1'b0);
        run_test(4, "random idle gaps on in_valid", 6, 1'b1);

        // One strobe per message, then nothing more while the input is quiet
        errs_before = error_count;
        assert (digest_count == msg_count) else begin
            $display("error digest_count expected 0x%0h actual 0x%0h", msg_count, digest_count);
            error_count++;
        end
        quiet_start = digest_count;
        repeat (50) @(posedge clk);
        assert (digest_count == quiet_start) else begin
            $display("An extra digest appeared during the quiet period");
            error_count++;
        end
        report_test(5, "digest count and quiet period", errs_before);

        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
absorb_pkg.sv
block_if.sv
load_fsm.sv
control_regs.sv
sipo_buffer.sv
block_absorber.sv
absorb_top.sv
absorb_assert.sv
absorb_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module absorb_tb -f vlog.f \
    -Mdir obj_dir -o absorb_sim || exit 1
./obj_dir/absorb_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1
